// File: src/audio_params.svh
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Channel count and per-channel buffering
`define AUDIO_CHANNELS 4
`define AUDIO_FIFO_DEPTH 4

// Rate register value after reset
`define AUDIO_DEFAULT_RATE 32'd17

// CPU register map
`define AUDIO_REG_RATE 8'hf0
`define AUDIO_REG_BUSY 8'h01

`endif

// File: src/audio_pkg.sv
package audio_pkg;

	// One signed PCM sample
	typedef logic signed [15:0] sample_t;

	typedef logic [31:0] word_t;
	typedef logic [31:0] address_t;

	// Transfer length in words
	typedef logic [23:0] count_t;

	// 15 is unity gain
	typedef logic [3:0] volume_t;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		WAIT,
		DONE
	} channel_state_t;

endpackage

// File: src/audio_channel.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_channel (
	input logic i_clock,
	input logic i_reset,
	input logic i_setup_strobe,
	input logic i_setup_stereo,
	input audio_pkg::address_t i_setup_address,
	input audio_pkg::count_t i_setup_count,
	input audio_pkg::volume_t i_volume,
	output logic o_dma_request,
	output audio_pkg::address_t o_dma_address,
	input logic i_dma_ready,
	input audio_pkg::word_t i_dma_rdata,
	input logic i_sample_strobe,
	output logic o_busy,
	output audio_pkg::sample_t o_sample_left,
	output audio_pkg::sample_t o_sample_right
);

	localparam int PTR_WIDTH = $clog2(`AUDIO_FIFO_DEPTH);

	audio_pkg::channel_state_t state;
	audio_pkg::count_t words_left;
	audio_pkg::address_t pending_address;
	logic discard;
	logic stereo;
	logic half;

	audio_pkg::word_t fifo [`AUDIO_FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH:0] fifo_count;
	logic fifo_empty;
	logic fifo_full;
	logic push;
	logic pop;
	audio_pkg::word_t head;
	audio_pkg::sample_t sample_low;
	audio_pkg::sample_t sample_high;

	// Gain of volume plus one, in sixteenths
	function automatic audio_pkg::sample_t scale(
		input audio_pkg::sample_t sample,
		input audio_pkg::volume_t volume
	);
		logic signed [5:0] gain;
		logic signed [21:0] product;
		logic signed [21:0] shifted;
		gain = $signed({2'b00, volume}) + 6'sd1;
		product = 22'(sample) * 22'(gain);
		shifted = product >>> 4;
		return shifted[15:0];
	endfunction

	assign fifo_empty = fifo_count == '0;
	assign fifo_full = fifo_count == (PTR_WIDTH + 1)'(`AUDIO_FIFO_DEPTH);
	assign head = fifo[rd_ptr];
	assign sample_low = head[15:0];
	assign sample_high = head[31:16];

	assign push = (state == audio_pkg::WAIT) && i_dma_ready && !discard && !i_setup_strobe;
	// Mono words stay until their high half has played
	assign pop = i_sample_strobe && !fifo_empty && (stereo || half);

	assign o_dma_request = state == audio_pkg::WAIT;
	assign o_busy = (words_left != '0) || !fifo_empty;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= audio_pkg::IDLE;
			words_left <= '0;
			discard <= 1'b0;
			stereo <= 1'b0;
		end else if (i_setup_strobe) begin
			words_left <= i_setup_count;
			stereo <= i_setup_stereo;
			if (state == audio_pkg::WAIT && !i_dma_ready) begin
				// Old read still outstanding, drop its data when it lands
				discard <= 1'b1;
				pending_address <= i_setup_address;
			end else begin
				discard <= 1'b0;
				o_dma_address <= i_setup_address;
				state <= (i_setup_count != '0) ? audio_pkg::WAIT : audio_pkg::DONE;
			end
		end else begin
			case (state)
				audio_pkg::FETCH: begin
					if (words_left == '0)
						state <= audio_pkg::DONE;
					else if (!fifo_full)
						state <= audio_pkg::WAIT;
				end
				audio_pkg::WAIT: begin
					if (i_dma_ready && discard) begin
						discard <= 1'b0;
						o_dma_address <= pending_address;
						state <= (words_left != '0) ? audio_pkg::FETCH : audio_pkg::DONE;
					end else if (i_dma_ready) begin
						o_dma_address <= o_dma_address + 32'd4;
						words_left <= words_left - 24'd1;
						state <= (words_left == 24'd1) ? audio_pkg::DONE : audio_pkg::FETCH;
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (push)
			fifo[wr_ptr] <= i_dma_rdata;
	end

	// Setup flushes the buffer
	always_ff @(posedge i_clock) begin
		if (i_reset || i_setup_strobe) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
			half <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + PTR_WIDTH'(1);
			if (pop)
				rd_ptr <= rd_ptr + PTR_WIDTH'(1);
			if (i_sample_strobe && !fifo_empty && !stereo)
				half <= !half;
			case ({push, pop})
				2'b10: fifo_count <= fifo_count + (PTR_WIDTH + 1)'(1);
				2'b01: fifo_count <= fifo_count - (PTR_WIDTH + 1)'(1);
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_sample_left <= '0;
			o_sample_right <= '0;
		end else if (i_sample_strobe) begin
			if (fifo_empty) begin
				// Underrun plays silence
				o_sample_left <= '0;
				o_sample_right <= '0;
			end else if (stereo) begin
				o_sample_left <= scale(sample_low, i_volume);
				o_sample_right <= scale(sample_high, i_volume);
			end else if (half) begin
				o_sample_left <= scale(sample_high, i_volume);
				o_sample_right <= scale(sample_high, i_volume);
			end else begin
				o_sample_left <= scale(sample_low, i_volume);
				o_sample_right <= scale(sample_low, i_volume);
			end
		end
	end

endmodule

// File: src/audio_registers.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_registers (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input logic [7:0] i_address,
	input audio_pkg::word_t i_wdata,
	output audio_pkg::word_t o_rdata,
	output logic o_ready,
	input logic [`AUDIO_CHANNELS-1:0] i_busy,
	output logic [`AUDIO_CHANNELS-1:0] o_setup_strobe,
	output logic [`AUDIO_CHANNELS-1:0] o_setup_stereo,
	output audio_pkg::address_t o_setup_address0, o_setup_address1,
	output audio_pkg::address_t o_setup_address2, o_setup_address3,
	output audio_pkg::count_t o_setup_count0, o_setup_count1,
	output audio_pkg::count_t o_setup_count2, o_setup_count3,
	output audio_pkg::volume_t o_volume0, o_volume1, o_volume2, o_volume3,
	output audio_pkg::word_t o_sample_rate
);

	// Per-channel offsets within each block of four
	localparam logic [1:0] OFFSET_ADDRESS = 2'd0;
	localparam logic [1:0] OFFSET_SETUP = 2'd1;
	localparam logic [1:0] OFFSET_VOLUME = 2'd2;

	audio_pkg::address_t setup_address [`AUDIO_CHANNELS];
	audio_pkg::count_t setup_count [`AUDIO_CHANNELS];
	audio_pkg::volume_t volume [`AUDIO_CHANNELS];
	logic [1:0] channel;
	logic channel_hit;

	assign channel = i_address[3:2];
	assign channel_hit = i_address[7:4] == 4'h0;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_setup_strobe <= '0;
			o_sample_rate <= `AUDIO_DEFAULT_RATE;
			for (int i = 0; i < `AUDIO_CHANNELS; i++)
				volume[i] <= 4'hf;
		end else begin
			o_setup_strobe <= '0;
			if (i_request && !o_ready) begin
				o_ready <= 1'b1;
				if (!i_rw) begin
					case (i_address)
						8'h00: o_rdata <= o_sample_rate;
						`AUDIO_REG_BUSY: o_rdata <= 32'(i_busy);
						default: o_rdata <= '0;
					endcase
				end else if (i_address == `AUDIO_REG_RATE) begin
					o_sample_rate <= i_wdata;
				end else if (channel_hit) begin
					case (i_address[1:0])
						OFFSET_ADDRESS: setup_address[channel] <= i_wdata;
						OFFSET_SETUP: begin
							setup_count[channel] <= i_wdata[23:0];
							o_setup_stereo[channel] <= i_wdata[29];
							o_setup_strobe[channel] <= 1'b1;
						end
						OFFSET_VOLUME: volume[channel] <= i_wdata[3:0];
						default: begin
						end
					endcase
				end
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
		end
	end

	assign o_setup_address0 = setup_address[0];
	assign o_setup_address1 = setup_address[1];
	assign o_setup_address2 = setup_address[2];
	assign o_setup_address3 = setup_address[3];
	assign o_setup_count0 = setup_count[0];
	assign o_setup_count1 = setup_count[1];
	assign o_setup_count2 = setup_count[2];
	assign o_setup_count3 = setup_count[3];
	assign o_volume0 = volume[0];
	assign o_volume1 = volume[1];
	assign o_volume2 = volume[2];
	assign o_volume3 = volume[3];

endmodule

// File: src/audio_dma_arbiter.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_dma_arbiter (
	input logic i_clock,
	input logic i_reset,
	input logic [`AUDIO_CHANNELS-1:0] i_request,
	input audio_pkg::address_t i_address0, i_address1, i_address2, i_address3,
	output logic [`AUDIO_CHANNELS-1:0] o_ready,
	output logic o_dma_request,
	output audio_pkg::address_t o_dma_address,
	input logic i_dma_ready
);

	localparam int POINTER_WIDTH = $clog2(`AUDIO_CHANNELS);

	logic [POINTER_WIDTH-1:0] pointer;
	audio_pkg::address_t addresses [`AUDIO_CHANNELS];

	assign addresses[0] = i_address0;
	assign addresses[1] = i_address1;
	assign addresses[2] = i_address2;
	assign addresses[3] = i_address3;

	// Only the granted channel sees the ready pulse
	assign o_ready = (o_dma_request && i_dma_ready) ?
		(`AUDIO_CHANNELS'(1) << pointer) : '0;

	// o_dma_request doubles as the grant lock
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pointer <= '0;
			o_dma_request <= 1'b0;
		end else if (o_dma_request) begin
			if (i_dma_ready) begin
				o_dma_request <= 1'b0;
				pointer <= pointer + POINTER_WIDTH'(1);
			end
		end else if (i_request[pointer]) begin
			o_dma_request <= 1'b1;
		end else begin
			pointer <= pointer + POINTER_WIDTH'(1);
		end
	end

	// Address frozen once granted
	always_ff @(posedge i_clock) begin
		if (!o_dma_request)
			o_dma_address <= addresses[pointer];
	end

endmodule

// File: src/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
	input logic i_clock,
	input logic i_reset,
	input audio_pkg::sample_t i_left0, i_left1, i_left2, i_left3,
	input audio_pkg::sample_t i_right0, i_right1, i_right2, i_right3,
	output audio_pkg::sample_t o_left,
	output audio_pkg::sample_t o_right
);

	// Two guard bits cover four full-scale inputs
	logic signed [17:0] sum_left;
	logic signed [17:0] sum_right;

	function automatic audio_pkg::sample_t clamp(input logic signed [17:0] sum);
		if (sum > 18'sd32767)
			return 16'h7fff;
		if (sum < -18'sd32768)
			return 16'h8000;
		return sum[15:0];
	endfunction

	assign sum_left = 18'(i_left0) + 18'(i_left1) + 18'(i_left2) + 18'(i_left3);
	assign sum_right = 18'(i_right0) + 18'(i_right1) + 18'(i_right2) + 18'(i_right3);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_left <= '0;
			o_right <= '0;
		end else begin
			o_left <= clamp(sum_left);
			o_right <= clamp(sum_right);
		end
	end

endmodule

// File: src/audio_controller.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_controller (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input logic [7:0] i_address,
	input audio_pkg::word_t i_wdata,
	output audio_pkg::word_t o_rdata,
	output logic o_ready,
	output logic o_dma_request,
	output audio_pkg::address_t o_dma_address,
	input logic i_dma_ready,
	input audio_pkg::word_t i_dma_rdata,
	input logic i_sample_strobe,
	output audio_pkg::word_t o_sample_rate,
	output audio_pkg::sample_t o_sample_left,
	output audio_pkg::sample_t o_sample_right
);

	logic [`AUDIO_CHANNELS-1:0] setup_strobe;
	logic [`AUDIO_CHANNELS-1:0] setup_stereo;
	logic [`AUDIO_CHANNELS-1:0] busy;
	logic [`AUDIO_CHANNELS-1:0] dma_request;
	logic [`AUDIO_CHANNELS-1:0] dma_ready;
	audio_pkg::address_t setup_address0, setup_address1, setup_address2, setup_address3;
	audio_pkg::count_t setup_count0, setup_count1, setup_count2, setup_count3;
	audio_pkg::volume_t volume0, volume1, volume2, volume3;
	audio_pkg::address_t dma_address0, dma_address1, dma_address2, dma_address3;
	audio_pkg::sample_t left0, left1, left2, left3;
	audio_pkg::sample_t right0, right1, right2, right3;

	audio_registers registers (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_request(i_request), .i_rw(i_rw), .i_address(i_address), .i_wdata(i_wdata),
		.o_rdata(o_rdata), .o_ready(o_ready), .i_busy(busy),
		.o_setup_strobe(setup_strobe), .o_setup_stereo(setup_stereo),
		.o_setup_address0(setup_address0), .o_setup_address1(setup_address1),
		.o_setup_address2(setup_address2), .o_setup_address3(setup_address3),
		.o_setup_count0(setup_count0), .o_setup_count1(setup_count1),
		.o_setup_count2(setup_count2), .o_setup_count3(setup_count3),
		.o_volume0(volume0), .o_volume1(volume1), .o_volume2(volume2), .o_volume3(volume3),
		.o_sample_rate(o_sample_rate)
	);

	audio_channel ch0 (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_setup_strobe(setup_strobe[0]), .i_setup_stereo(setup_stereo[0]),
		.i_setup_address(setup_address0), .i_setup_count(setup_count0), .i_volume(volume0),
		.o_dma_request(dma_request[0]), .o_dma_address(dma_address0),
		.i_dma_ready(dma_ready[0]), .i_dma_rdata(i_dma_rdata),
		.i_sample_strobe(i_sample_strobe), .o_busy(busy[0]),
		.o_sample_left(left0), .o_sample_right(right0)
	);

	audio_channel ch1 (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_setup_strobe(setup_strobe[1]), .i_setup_stereo(setup_stereo[1]),
		.i_setup_address(setup_address1), .i_setup_count(setup_count1), .i_volume(volume1),
		.o_dma_request(dma_request[1]), .o_dma_address(dma_address1),
		.i_dma_ready(dma_ready[1]), .i_dma_rdata(i_dma_rdata),
		.i_sample_strobe(i_sample_strobe), .o_busy(busy[1]),
		.o_sample_left(left1), .o_sample_right(right1)
	);

	audio_channel ch2 (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_setup_strobe(setup_strobe[2]), .i_setup_stereo(setup_stereo[2]),
		.i_setup_address(setup_address2), .i_setup_count(setup_count2), .i_volume(volume2),
		.o_dma_request(dma_request[2]), .o_dma_address(dma_address2),
		.i_dma_ready(dma_ready[2]), .i_dma_rdata(i_dma_rdata),
		.i_sample_strobe(i_sample_strobe), .o_busy(busy[2]),
		.o_sample_left(left2), .o_sample_right(right2)
	);

	audio_channel ch3 (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_setup_strobe(setup_strobe[3]), .i_setup_stereo(setup_stereo[3]),
		.i_setup_address(setup_address3), .i_setup_count(setup_count3), .i_volume(volume3),
		.o_dma_request(dma_request[3]), .o_dma_address(dma_address3),
		.i_dma_ready(dma_ready[3]), .i_dma_rdata(i_dma_rdata),
		.i_sample_strobe(i_sample_strobe), .o_busy(busy[3]),
		.o_sample_left(left3), .o_sample_right(right3)
	);

	audio_dma_arbiter arbiter (
		.i_clock(i_clock), .i_reset(i_reset), .i_request(dma_request),
		.i_address0(dma_address0), .i_address1(dma_address1),
		.i_address2(dma_address2), .i_address3(dma_address3),
		.o_ready(dma_ready), .o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address), .i_dma_ready(i_dma_ready)
	);

	audio_mixer mixer (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_left0(left0), .i_left1(left1), .i_left2(left2), .i_left3(left3),
		.i_right0(right0), .i_right1(right1), .i_right2(right2), .i_right3(right3),
		.o_left(o_sample_left), .o_right(o_sample_right)
	);

endmodule

// File: verification/audio_controller_tb.sv
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_controller_tb;

	localparam int SPACING = 60;
	localparam int STROBE_TOTAL = 70;
	localparam int MARGIN = 6000;

	logic i_clock;
	logic i_reset;
	logic i_request;
	logic i_rw;
	logic [7:0] i_address;
	audio_pkg::word_t i_wdata;
	audio_pkg::word_t o_rdata;
	logic o_ready;
	logic o_dma_request;
	audio_pkg::address_t o_dma_address;
	logic i_dma_ready;
	audio_pkg::word_t i_dma_rdata;
	logic i_sample_strobe;
	audio_pkg::word_t o_sample_rate;
	audio_pkg::sample_t o_sample_left;
	audio_pkg::sample_t o_sample_right;

	logic [31:0] stim_rng;
	logic [31:0] mem_rng;
	logic [31:0] rdata_seen;

	// Reference model per channel
	logic [31:0] m_next [4];
	int m_left [4];
	bit m_half [4];
	bit m_stereo [4];
	int m_vol [4];

	// Memory regions handed out by setups
	logic [31:0] region_base [32];
	logic [31:0] region_end [32];
	logic [31:0] region_last [32];
	int region_count;

	audio_controller UUT (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_request(i_request), .i_rw(i_rw), .i_address(i_address), .i_wdata(i_wdata),
		.o_rdata(o_rdata), .o_ready(o_ready),
		.o_dma_request(o_dma_request), .o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready), .i_dma_rdata(i_dma_rdata),
		.i_sample_strobe(i_sample_strobe), .o_sample_rate(o_sample_rate),
		.o_sample_left(o_sample_left), .o_sample_right(o_sample_right)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] scramble(input logic [31:0] address);
		return {address[24:0], address[31:25]} ^ 32'hA5A5_5A5A;
	endfunction

	function automatic int scaled(input logic [15:0] sample, input int volume);
		int s;
		s = int'($signed(sample));
		return (s * (volume + 1)) >>> 4;
	endfunction

	function automatic logic [31:0] saturate(input int sum);
		if (sum > 32767)
			return 32'h7fff;
		if (sum < -32768)
			return 32'h8000;
		return {16'h0, sum[15:0]};
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s expected %h got %h", $time, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic next_cycle();
		@(posedge i_clock);
		#2;
	endtask

	task automatic cpu_access(input logic rw, input logic [7:0] address,
		input logic [31:0] data);
		int cycles;
		cycles = 0;
		i_request = 1'b1;
		i_rw = rw;
		i_address = address;
		i_wdata = data;
		do begin
			next_cycle();
			cycles++;
			if (cycles > 8) begin
				$display("Simulation failed");
				$fatal(1, "CPU port never raised ready");
			end
		end while (!o_ready);
		check_value(cycles, 1, "ready latency");
		rdata_seen = o_rdata;
		next_cycle();
		check_value(32'(o_ready), 32'd1, "ready held");
		i_request = 1'b0;
		next_cycle();
		check_value(32'(o_ready), 32'd0, "ready release");
	endtask

	task automatic setup_channel(input int ch, input int count, input bit stereo,
		input int volume);
		logic [31:0] base;
		stim_rng = xorshift(stim_rng);
		base = ((region_count + 1) << 16) + (stim_rng & 32'h0ffc);
		region_base[region_count] = base;
		region_end[region_count] = base + 4 * count;
		region_last[region_count] = base - 4;
		region_count++;
		cpu_access(1'b1, 8'(4 * ch), base);
		cpu_access(1'b1, 8'(4 * ch + 2), 32'(volume));
		cpu_access(1'b1, 8'(4 * ch + 1), (32'(stereo) << 29) | 32'(count));
		m_next[ch] = base;
		m_left[ch] = count;
		m_half[ch] = 1'b0;
		m_stereo[ch] = stereo;
		m_vol[ch] = volume;
		repeat (SPACING) next_cycle();
	endtask

	task automatic strobe_and_check();
		int sum_l;
		int sum_r;
		logic [31:0] word;
		repeat (SPACING) next_cycle();
		sum_l = 0;
		sum_r = 0;
		for (int ch = 0; ch < 4; ch++) begin
			if (m_left[ch] != 0) begin
				word = scramble(m_next[ch]);
				if (m_stereo[ch]) begin
					sum_l += scaled(word[15:0], m_vol[ch]);
					sum_r += scaled(word[31:16], m_vol[ch]);
					m_next[ch] += 4;
					m_left[ch]--;
				end else if (!m_half[ch]) begin
					sum_l += scaled(word[15:0], m_vol[ch]);
					sum_r += scaled(word[15:0], m_vol[ch]);
					m_half[ch] = 1'b1;
				end else begin
					sum_l += scaled(word[31:16], m_vol[ch]);
					sum_r += scaled(word[31:16], m_vol[ch]);
					m_half[ch] = 1'b0;
					m_next[ch] += 4;
					m_left[ch]--;
				end
			end
		end
		i_sample_strobe = 1'b1;
		next_cycle();
		i_sample_strobe = 1'b0;
		next_cycle();
		check_value({16'h0, o_sample_left}, saturate(sum_l), "left sample");
		check_value({16'h0, o_sample_right}, saturate(sum_r), "right sample");
	endtask

	task automatic check_busy();
		logic [31:0] expected;
		expected = '0;
		for (int ch = 0; ch < 4; ch++)
			expected[ch] = m_left[ch] != 0;
		cpu_access(1'b0, `AUDIO_REG_BUSY, '0);
		check_value(rdata_seen, expected, "busy bits");
	endtask

	initial begin
		i_clock = 1'b0;
		forever #20 i_clock = ~i_clock;
	end

	initial begin
		#((STROBE_TOTAL * SPACING + MARGIN) * 40);
		$display("Simulation failed");
		$fatal(1, "Watchdog expired before the tests finished");
	end

	// Memory model with random latency
	initial begin
		int latency;
		bit found;
		mem_rng = 32'h0504_d3f9 ^ 32'h1357_9bdf;
		i_dma_ready = 1'b0;
		i_dma_rdata = '0;
		forever begin
			next_cycle();
			if (o_dma_request && !i_reset) begin
				found = 1'b0;
				for (int r = 0; r < region_count; r++) begin
					if (o_dma_address >= region_base[r] && o_dma_address < region_end[r]) begin
						found = 1'b1;
						check_value(32'(o_dma_address > region_last[r]), 1, "address order");
						region_last[r] = o_dma_address;
					end
				end
				check_value(32'(found), 1, "address in active region");
				mem_rng = xorshift(mem_rng);
				latency = int'(mem_rng % 4) + 1;
				repeat (latency - 1) next_cycle();
				i_dma_ready = 1'b1;
				i_dma_rdata = scramble(o_dma_address);
				next_cycle();
				i_dma_ready = 1'b0;
			end
		end
	end

	initial begin
		logic [31:0] rate;
		stim_rng = 32'h0504_d3f9;
		region_count = 0;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_sample_strobe = 1'b0;
		for (int ch = 0; ch < 4; ch++) begin
			m_next[ch] = '0;
			m_left[ch] = 0;
			m_half[ch] = 1'b0;
			m_stereo[ch] = 1'b0;
			m_vol[ch] = 15;
		end
		repeat (4) @(posedge i_clock);
		#2;
		i_reset = 1'b0;
		check_value(32'(o_ready), 32'd0, "ready after reset");
		check_value(32'(o_dma_request), 32'd0, "DMA request after reset");
		check_value({16'h0, o_sample_left}, 32'd0, "left sample after reset");
		check_value({16'h0, o_sample_right}, 32'd0, "right sample after reset");
		check_value(o_sample_rate, `AUDIO_DEFAULT_RATE, "rate output after reset");

		// Register port
		cpu_access(1'b0, 8'h00, '0);
		check_value(rdata_seen, `AUDIO_DEFAULT_RATE, "default rate");
		check_busy();
		for (int i = 0; i < 3; i++) begin
			stim_rng = xorshift(stim_rng);
			rate = stim_rng;
			cpu_access(1'b1, `AUDIO_REG_RATE, rate);
			cpu_access(1'b0, 8'h00, '0);
			check_value(rdata_seen, rate, "rate readback");
			check_value(o_sample_rate, rate, "rate output");
		end
		stim_rng = xorshift(stim_rng);
		cpu_access(1'b1, 8'h33, stim_rng);
		cpu_access(1'b1, 8'h03, stim_rng);
		cpu_access(1'b0, 8'h00, '0);
		check_value(rdata_seen, rate, "rate after unused writes");
		cpu_access(1'b0, 8'h02, '0);
		check_value(rdata_seen, '0, "unused read");
		check_busy();

		// Stereo at unity gain, then underrun
		setup_channel(0, 6, 1'b1, 15);
		for (int i = 0; i < 8; i++)
			strobe_and_check();
		check_busy();

		// Mono with random volume
		stim_rng = xorshift(stim_rng);
		setup_channel(1, 5, 1'b0, int'(stim_rng % 16));
		for (int i = 0; i < 11; i++)
			strobe_and_check();
		check_busy();

		// All channels mixed
		for (int ch = 0; ch < 4; ch++) begin
			stim_rng = xorshift(stim_rng);
			setup_channel(ch, int'(stim_rng % 10) + 3, stim_rng[8], int'(stim_rng[15:12]));
		end
		for (int i = 0; i < 30; i++) begin
			strobe_and_check();
			if (i % 10 == 9)
				check_busy();
		end

		// Setup rewritten mid-playback
		for (int ch = 0; ch < 4; ch++) begin
			stim_rng = xorshift(stim_rng);
			setup_channel(ch, 30, stim_rng[3], int'(stim_rng[23:20]));
		end
		for (int i = 0; i < 5; i++)
			strobe_and_check();
		// Each rewrite lands just after a strobe, while refills are in flight
		for (int ch = 0; ch < 4; ch++) begin
			stim_rng = xorshift(stim_rng);
			setup_channel(ch, 8, stim_rng[5], int'(stim_rng[11:8]));
			strobe_and_check();
		end
		for (int i = 0; i < 12; i++)
			strobe_and_check();
		check_busy();

		$display("Simulation passed");
		$finish;
	end

endmodule

// File: audio_controller.f
+incdir+src
src/audio_pkg.sv
src/audio_channel.sv
src/audio_registers.sv
src/audio_dma_arbiter.sv
src/audio_mixer.sv
src/audio_controller.sv
verification/audio_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the audio controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall -f audio_controller.f \
	--top-module audio_controller_tb -o audio_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/audio_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation run failed with status $status"
	exit $status
fi

exit 0
